/* vlog.f */
+incdir+include
logic/dmaPkg.sv
logic/cpuProgrammer.sv
logic/dmaController.sv
logic/sharedMemory.sv
logic/ioDevice.sv
logic/dmaSystem.sv
tests/dmaSystemTb.sv

/* runSim.sh */
#!/bin/sh
# build the DMA testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module dmaSystemTb -f vlog.f --Mdir obj_dir -o simDma
then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/simDma > sim.log 2>&1
then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log

if grep -q "tests failed" sim.log
then
  exit 1
fi
exit 0

/* include/dmaTestTable.svh */
`ifndef DMA_TEST_TABLE_SVH
`define DMA_TEST_TABLE_SVH

// name is packed so it prints with %s
typedef struct packed
{
  logic [8*16-1:0] name;
  logic [dmaPkg::dataWidth-1:0] cmdData;
  logic [dmaPkg::dataWidth-1:0] modeData;
  logic [dmaPkg::addrWidth-1:0] baseAddr;
  logic [dmaPkg::addrWidth-1:0] baseCount;
  logic [dmaPkg::dataWidth-1:0] ioSeed;
  logic [dmaPkg::addrWidth-1:0] ioLength;
} dmaTestCase;

localparam int numTests = 6;
localparam int disabledWindow = 80;      // cycles to wait when no EOP should come

// mode byte is {mode[1:0], dec, autoinit, type[1:0], channel[1:0]}
localparam dmaTestCase testTable [numTests] = '{
  '{"blockIncWrite",  8'h00, 8'h84, 16'h0010, 16'd7,  8'hA0, 16'd8},
  '{"singleDecWrite", 8'h00, 8'h64, 16'h0060, 16'd4,  8'h30, 16'd5},
  '{"blockIncRead",   8'h00, 8'h88, 16'h0080, 16'd15, 8'h00, 16'd16},
  '{"singleIncRead",  8'h00, 8'h48, 16'h00C0, 16'd3,  8'h00, 16'd4},
  '{"demandWrite",    8'h00, 8'h04, 16'h00E0, 16'd2,  8'h55, 16'd3},
  '{"disabled",       8'h04, 8'h84, 16'h0040, 16'd3,  8'h11, 16'd4}
};

`endif

/* tests/dmaSystemTb.sv */
`timescale 1ns/1ps

module dmaSystemTb;
  import dmaPkg::*;

  `include "dmaTestTable.svh"

  localparam logic [31:0] lcgSeed = 32'h84b229e8;

  logic CLK;
  logic RESET;
  logic start;
  logic [dataWidth-1:0] cmdData;
  logic [dataWidth-1:0] modeData;
  logic [addrWidth-1:0] baseAddr;
  logic [addrWidth-1:0] baseCount;
  logic [dataWidth-1:0] ioSeed;
  logic [addrWidth-1:0] ioLength;
  logic [addrWidth-1:0] hostAddr;
  logic [dataWidth-1:0] hostWrData;
  logic hostWe;
  logic [dataWidth-1:0] hostRdData;
  logic hostBusy;
  logic EOP;
  logic [2*dataWidth-1:0] ioChecksum;
  logic [addrWidth-1:0] ioByteCount;

  logic [dataWidth-1:0] expMem [memDepth];      // reference image of memory
  logic [31:0] lcgState;
  string curName;
  int errCount;
  int passCount;
  int failCount;
  int cycleCount = 0;
  int cycleLimit;

  dmaSystem uut (.CLK, .RESET, .start, .cmdData, .modeData, .baseAddr, .baseCount,
    .ioSeed, .ioLength, .hostAddr, .hostWrData, .hostWe, .hostRdData, .hostBusy, .EOP,
    .ioChecksum, .ioByteCount);

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // per row: programming and hold slack, every byte at single-mode cost, preload and readback
  function automatic int transferBudget();
    int total;
    total = 200;                                // reset and host port checks
    for (int i = 0; i < numTests; i++)
      total += 20 + 2 * (holdWait + 3) * (int'(testTable[i].baseCount) + 1)
        + 3 * memDepth + disabledWindow;
    return total;
  endfunction

  task automatic checkValue(input string what, input logic [31:0] expected,
    input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Mismatch in %s: %s expected %h actual %h", curName, what, expected, actual);
      errCount++;
    end
  endtask

  task automatic writeHost(input int addr, input logic [dataWidth-1:0] data);
    @(posedge CLK);
    hostAddr <= addrWidth'(addr);
    hostWrData <= data;
    hostWe <= 1'b1;
  endtask

  // registered read, sampled at the falling edge once rdData has settled
  task automatic readHost(input int addr, output logic [dataWidth-1:0] data);
    @(posedge CLK);
    hostAddr <= addrWidth'(addr);
    hostWe <= 1'b0;
    @(posedge CLK);
    @(negedge CLK);
    data = hostRdData;
  endtask

  task automatic preloadMemory();
    for (int a = 0; a < memDepth; a++)
    begin
      lcgState = lcgNext(lcgState);
      expMem[a] = lcgState[31:24];
      writeHost(a, lcgState[31:24]);
    end
    @(posedge CLK);
    hostWe <= 1'b0;
  endtask

  task automatic checkMemory();
    logic [dataWidth-1:0] got;
    for (int a = 0; a < memDepth; a++)
    begin
      readHost(a, got);
      checkValue($sformatf("mem[%02h]", a), 32'(expMem[a]), 32'(got));
    end
  endtask

  task automatic pulseStart();
    @(posedge CLK);
    start <= 1'b1;
    @(posedge CLK);
    start <= 1'b0;
  endtask

  // one host write goes in while the controller owns memory, it must be dropped
  task automatic waitEop(input logic [memAddrWidth-1:0] probeAddr);
    bit probed;
    bit done;
    probed = 1'b0;
    done = 1'b0;
    while (!done)
    begin
      @(negedge CLK);
      if (EOP)
        done = 1'b1;
      else if (hostBusy && !probed)
      begin
        probed = 1'b1;
        @(posedge CLK);
        hostAddr <= addrWidth'(probeAddr);
        hostWrData <= ~expMem[probeAddr];       // differs from the preload byte
        hostWe <= 1'b1;
        @(posedge CLK);
        hostWe <= 1'b0;
      end
    end
    checkValue("host write tried while busy", 32'd1, 32'(probed));
    while (hostBusy)
      @(negedge CLK);
  endtask

  task automatic watchIdle(output bit sawEop, output bit sawBusy);
    sawEop = 1'b0;
    sawBusy = 1'b0;
    repeat (disabledWindow)
    begin
      @(negedge CLK);
      if (EOP)
        sawEop = 1'b1;
      if (hostBusy)
        sawBusy = 1'b1;
    end
  endtask

  task automatic reportTest();
    if (errCount == 0)
    begin
      passCount++;
      $display("test %s: ok", curName);
    end
    else
    begin
      failCount++;
      $display("test %s: %0d errors", curName, errCount);
    end
  endtask

  task automatic checkResetState();
    logic [dataWidth-1:0] data [4];
    logic [dataWidth-1:0] got;
    curName = "resetState";
    errCount = 0;
    @(negedge CLK);
    checkValue("hostBusy", 32'd0, 32'(hostBusy));
    checkValue("EOP", 32'd0, 32'(EOP));
    for (int i = 0; i < 4; i++)
    begin
      lcgState = lcgNext(lcgState);
      data[i] = lcgState[31:24];
      writeHost(8'h20 + 3 * i, data[i]);
    end
    @(posedge CLK);
    hostWe <= 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      readHost(8'h20 + 3 * i, got);
      checkValue($sformatf("mem[%02h]", 8'h20 + 3 * i), 32'(data[i]), 32'(got));
    end
    reportTest();
  endtask

  task automatic applyRow(input dmaTestCase row);
    xferType kind;
    bit decrement;
    bit enabled;
    bit sawEop;
    bit sawBusy;
    logic [memAddrWidth-1:0] offset;
    logic [memAddrWidth-1:0] idx;
    logic [memAddrWidth-1:0] probeAddr;
    logic [15:0] sum;
    curName = string'(row.name);
    errCount = 0;
    @(posedge CLK);
    cmdData <= row.cmdData;
    modeData <= row.modeData;
    baseAddr <= row.baseAddr;
    baseCount <= row.baseCount;
    ioSeed <= row.ioSeed;
    ioLength <= row.ioLength;
    preloadMemory();

    // expected results from the mode and command bits
    kind = xferType'(row.modeData[3:2]);
    decrement = row.modeData[modeDecBit];
    enabled = !row.cmdData[cmdDisableBit];
    sum = '0;
    for (int i = 0; i <= int'(row.baseCount); i++)
    begin
      offset = memAddrWidth'(i);
      idx = decrement ? row.baseAddr[memAddrWidth-1:0] - offset
                      : row.baseAddr[memAddrWidth-1:0] + offset;
      if (enabled && kind == xferRead)
        sum = sum + 16'(expMem[idx]);
      else if (enabled && kind == xferWrite)
        expMem[idx] = row.ioSeed + offset;     // counted bytes from the device
    end
    probeAddr = row.baseAddr[memAddrWidth-1:0] + 8'h80;   // outside every transfer range

    pulseStart();
    if (enabled)
    begin
      waitEop(probeAddr);
      checkValue("ioByteCount", 32'(row.baseCount) + 32'd1, 32'(ioByteCount));
      if (kind == xferRead)
        checkValue("ioChecksum", 32'(sum), 32'(ioChecksum));
    end
    else
    begin
      watchIdle(sawEop, sawBusy);
      checkValue("EOP while disabled", 32'd0, 32'(sawEop));
      checkValue("hostBusy while disabled", 32'd0, 32'(sawBusy));
    end
    checkMemory();
    reportTest();
  endtask

  always @(posedge CLK)
  begin
    cycleCount++;
    if (cycleCount > cycleLimit)
    begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("tests failed");
      $finish;
    end
  end

  initial
  begin
    RESET <= 1'b1;
    start <= 1'b0;
    cmdData <= '0;
    modeData <= '0;
    baseAddr <= '0;
    baseCount <= '0;
    ioSeed <= '0;
    ioLength <= '0;
    hostAddr <= '0;
    hostWrData <= '0;
    hostWe <= 1'b0;
    lcgState = lcgSeed;
    passCount = 0;
    failCount = 0;
    errCount = 0;
    cycleLimit = transferBudget();
    repeat (4) @(posedge CLK);
    RESET <= 1'b0;

    checkResetState();
    for (int t = 0; t < numTests; t++)
      applyRow(testTable[t]);

    $display("summary: %0d passed, %0d failed", passCount, failCount);
    if (failCount == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

/* logic/dmaSystem.sv */
`timescale 1ns/1ps

module dmaSystem
(
  input  logic CLK,
  input  logic RESET,
  input  logic start,
  input  logic [dmaPkg::dataWidth-1:0] cmdData,
  input  logic [dmaPkg::dataWidth-1:0] modeData,
  input  logic [dmaPkg::addrWidth-1:0] baseAddr,
  input  logic [dmaPkg::addrWidth-1:0] baseCount,
  input  logic [dmaPkg::dataWidth-1:0] ioSeed,
  input  logic [dmaPkg::addrWidth-1:0] ioLength,
  input  logic [dmaPkg::addrWidth-1:0] hostAddr,
  input  logic [dmaPkg::dataWidth-1:0] hostWrData,
  input  logic hostWe,
  output logic [dmaPkg::dataWidth-1:0] hostRdData,
  output logic hostBusy,
  output logic EOP,
  output logic [2*dmaPkg::dataWidth-1:0] ioChecksum,
  output logic [dmaPkg::addrWidth-1:0] ioByteCount
);
  import dmaPkg::*;

  logic CS_N;
  logic IOW_N;
  logic [regAddrWidth-1:0] regAddr;
  logic [dataWidth-1:0] DB;
  logic HRQ;
  logic HLDA;
  logic configured;
  logic DREQ;
  logic DACK;
  logic ioRead;
  logic ioWrite;
  logic [addrWidth-1:0] dmaAddr;
  logic [dataWidth-1:0] dmaWrData;
  logic dmaWe;
  logic [dataWidth-1:0] ioDataIn;
  logic [dataWidth-1:0] ioDataOut;

  cpuProgrammer cpu (.CLK, .RESET, .start, .cmdData, .modeData, .baseAddr, .baseCount,
    .HRQ, .intEOP(EOP), .CS_N, .IOW_N, .regAddr, .DB, .HLDA, .configured);

  dmaController dmac (.CLK, .RESET, .CS_N, .IOW_N, .regAddr, .DB, .configured, .HLDA,
    .DREQ, .memRdData(hostRdData), .ioDataOut, .HRQ, .DACK, .ioRead, .ioWrite, .dmaAddr,
    .dmaWrData, .dmaWe, .ioDataIn, .EOP);

  // one read port serves host and controller
  sharedMemory mem (.CLK, .HLDA, .hostAddr, .hostWrData, .hostWe, .dmaAddr, .dmaWrData,
    .dmaWe, .rdData(hostRdData), .hostBusy);

  ioDevice dev (.CLK, .RESET, .configured, .modeData, .ioSeed, .ioLength, .DACK, .ioRead,
    .ioWrite, .ioDataIn, .DREQ, .ioDataOut, .ioChecksum, .ioByteCount);

endmodule

/* logic/ioDevice.sv */
`timescale 1ns/1ps

module ioDevice
(
  input  logic CLK,
  input  logic RESET,
  input  logic configured,
  input  logic [dmaPkg::dataWidth-1:0] modeData,
  input  logic [dmaPkg::dataWidth-1:0] ioSeed,
  input  logic [dmaPkg::addrWidth-1:0] ioLength,
  input  logic DACK,
  input  logic ioRead,
  input  logic ioWrite,
  input  logic [dmaPkg::dataWidth-1:0] ioDataIn,
  output logic DREQ,
  output logic [dmaPkg::dataWidth-1:0] ioDataOut,
  output logic [2*dmaPkg::dataWidth-1:0] ioChecksum,
  output logic [dmaPkg::addrWidth-1:0] ioByteCount
);
  import dmaPkg::*;

  xferType xfer;
  logic configuredDly;
  logic newRun;

  assign xfer = xferType'(modeData[3:2]);
  assign newRun = configured && !configuredDly;

  // level request, held off for the cycle the counters are being cleared
  assign DREQ = configured && configuredDly && (ioByteCount < ioLength);

  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      configuredDly <= 1'b0;
      ioByteCount <= '0;
      ioChecksum <= '0;
      ioDataOut <= '0;
    end
    else
    begin
      configuredDly <= configured;
      if (newRun)
      begin
        ioByteCount <= '0;
        ioChecksum <= '0;
        ioDataOut <= ioSeed;
      end
      else if (DACK)
      begin
        ioByteCount <= ioByteCount + 1'b1;
        // write mode offers the next counted byte
        if (ioRead && xfer == xferWrite)
          ioDataOut <= ioDataOut + 1'b1;
        if (ioWrite && xfer == xferRead)
          ioChecksum <= ioChecksum + {{dataWidth{1'b0}}, ioDataIn};  // read mode sink
      end
    end
  end

endmodule

/* logic/sharedMemory.sv */
`timescale 1ns/1ps

module sharedMemory
(
  input  logic CLK,
  input  logic HLDA,
  input  logic [dmaPkg::addrWidth-1:0] hostAddr,
  input  logic [dmaPkg::dataWidth-1:0] hostWrData,
  input  logic hostWe,
  input  logic [dmaPkg::addrWidth-1:0] dmaAddr,
  input  logic [dmaPkg::dataWidth-1:0] dmaWrData,
  input  logic dmaWe,
  output logic [dmaPkg::dataWidth-1:0] rdData,
  output logic hostBusy
);
  import dmaPkg::*;

  logic [dataWidth-1:0] mem [memDepth];
  logic [memAddrWidth-1:0] addr;
  logic [dataWidth-1:0] wrData;
  logic we;

  // HLDA hands the single port to the DMA side
  always_comb
  begin
    if (HLDA)
    begin
      addr = dmaAddr[memAddrWidth-1:0];
      wrData = dmaWrData;
      we = dmaWe;
    end
    else
    begin
      addr = hostAddr[memAddrWidth-1:0];
      wrData = hostWrData;
      we = hostWe;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (we)
      mem[addr] <= wrData;
    rdData <= mem[addr];                 // one cycle read latency
  end

  assign hostBusy = HLDA;                // host writes are dropped while held

endmodule

/* logic/dmaController.sv */
`timescale 1ns/1ps

module dmaController
(
  input  logic CLK,
  input  logic RESET,
  input  logic CS_N,
  input  logic IOW_N,
  input  logic [dmaPkg::regAddrWidth-1:0] regAddr,
  input  logic [dmaPkg::dataWidth-1:0] DB,
  input  logic configured,
  input  logic HLDA,
  input  logic DREQ,
  input  logic [dmaPkg::dataWidth-1:0] memRdData,
  input  logic [dmaPkg::dataWidth-1:0] ioDataOut,
  output logic HRQ,
  output logic DACK,
  output logic ioRead,
  output logic ioWrite,
  output logic [dmaPkg::addrWidth-1:0] dmaAddr,
  output logic [dmaPkg::dataWidth-1:0] dmaWrData,
  output logic dmaWe,
  output logic [dmaPkg::dataWidth-1:0] ioDataIn,
  output logic EOP
);
  import dmaPkg::*;

  logic [dataWidth-1:0] cmdReg;
  logic [dataWidth-1:0] modeReg;
  logic [addrWidth-1:0] baseAddrReg;
  logic [addrWidth-1:0] currAddr;
  logic [addrWidth-1:0] baseCountReg;
  logic [addrWidth-1:0] currCount;
  logic bytePtr;                         // low/high byte flip-flop
  logic regWrite;
  logic enabled;
  logic burst;
  logic lastByte;
  xferType xfer;
  dmaState state;

  assign regWrite = !CS_N && !IOW_N;
  assign enabled = !cmdReg[cmdDisableBit];
  assign xfer = xferType'(modeReg[3:2]);
  assign lastByte = (currCount == '0);   // count wraps below zero on this byte

  // demand mode keeps the bus like block mode
  always_comb
  begin
    case (xferMode'(modeReg[7:6]))
      modeSingle:
        burst = 1'b0;
      modeBlock, modeDemand:
        burst = 1'b1;
      default:
        burst = 1'b1;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      cmdReg <= '0;
      modeReg <= '0;
      baseAddrReg <= '0;
      currAddr <= '0;
      baseCountReg <= '0;
      currCount <= '0;
      bytePtr <= 1'b0;
    end
    else if (regWrite)
    begin
      case (regAddr)
        cmdRegAddr:
        begin
          cmdReg <= DB;
          bytePtr <= 1'b0;
        end
        modeRegAddr:
          modeReg <= DB;
        ch0AddrRegAddr:
        begin
          // high byte completes the base and loads the current address
          if (bytePtr)
          begin
            baseAddrReg[addrWidth-1:dataWidth] <= DB;
            currAddr <= {DB, baseAddrReg[dataWidth-1:0]};
          end
          else
            baseAddrReg[dataWidth-1:0] <= DB;
          bytePtr <= ~bytePtr;
        end
        ch0CountRegAddr:
        begin
          if (bytePtr)
          begin
            baseCountReg[addrWidth-1:dataWidth] <= DB;
            currCount <= {DB, baseCountReg[dataWidth-1:0]};
          end
          else
            baseCountReg[dataWidth-1:0] <= DB;
          bytePtr <= ~bytePtr;
        end
        default: ;
      endcase
    end
    else if (state == dmaData)
    begin
      currAddr <= modeReg[modeDecBit] ? currAddr - 1'b1 : currAddr + 1'b1;
      currCount <= currCount - 1'b1;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      state <= dmaIdle;
      HRQ <= 1'b0;
    end
    else
    begin
      case (state)
        dmaIdle:
          if (configured && DREQ && enabled)
          begin
            state <= dmaRequest;
            HRQ <= 1'b1;
          end
        dmaRequest:
          if (HLDA && DREQ)
            state <= dmaAddress;
        dmaAddress:
          if (DREQ)
            state <= dmaData;
          else
            state <= dmaRequest;         // back-pressure, bus stays held
        dmaData:
          if (lastByte)
          begin
            state <= dmaEnd;
            HRQ <= 1'b0;
          end
          else if (burst)
            state <= dmaAddress;
          else
          begin
            state <= dmaIdle;            // single mode releases after each byte
            HRQ <= 1'b0;
          end
        dmaEnd:
          state <= dmaIdle;
        default:
          state <= dmaIdle;
      endcase
    end
  end

  // verify cycles strobe neither side
  assign DACK = (state == dmaData);
  assign ioRead = DACK && (xfer == xferWrite);
  assign ioWrite = DACK && (xfer == xferRead);
  assign dmaWe = DACK && (xfer == xferWrite);
  assign dmaAddr = currAddr;
  assign dmaWrData = ioDataOut;
  assign ioDataIn = memRdData;           // read data lands during dmaData
  assign EOP = (state == dmaEnd);

endmodule

/* logic/cpuProgrammer.sv */
`timescale 1ns/1ps

module cpuProgrammer
(
  input  logic CLK,
  input  logic RESET,
  input  logic start,
  input  logic [dmaPkg::dataWidth-1:0] cmdData,
  input  logic [dmaPkg::dataWidth-1:0] modeData,
  input  logic [dmaPkg::addrWidth-1:0] baseAddr,
  input  logic [dmaPkg::addrWidth-1:0] baseCount,
  input  logic HRQ,
  input  logic intEOP,
  output logic CS_N,
  output logic IOW_N,
  output logic [dmaPkg::regAddrWidth-1:0] regAddr,
  output logic [dmaPkg::dataWidth-1:0] DB,
  output logic HLDA,
  output logic configured
);
  import dmaPkg::*;

  localparam int holdBits = $clog2(holdWait + 1);

  progState state;
  progState nextState;
  logic writeCycle;
  logic [holdBits-1:0] holdCnt;

  always_ff @(posedge CLK)
  begin
    if (RESET)
      state <= progIdle;
    else
      state <= nextState;
  end

  // one register write per cycle once started
  always_comb
  begin
    nextState = state;
    case (state)
      progIdle:
        if (start)
          nextState = progCmd;
      progCmd:       nextState = progMode;
      progMode:      nextState = progAddrLow;
      progAddrLow:   nextState = progAddrHigh;
      progAddrHigh:  nextState = progCountLow;
      progCountLow:  nextState = progCountHigh;
      progCountHigh: nextState = progDone;
      progDone:
      begin
        if (intEOP)
          nextState = progIdle;          // transfer finished
        else if (start)
          nextState = progCmd;           // reprogram without a transfer
      end
      default:       nextState = progIdle;
    endcase
  end

  always_comb
  begin
    writeCycle = 1'b1;
    regAddr = '0;
    DB = '0;
    case (state)
      progCmd:
      begin
        regAddr = cmdRegAddr;
        DB = cmdData;
      end
      progMode:
      begin
        regAddr = modeRegAddr;
        DB = modeData;
      end
      progAddrLow:
      begin
        regAddr = ch0AddrRegAddr;
        DB = baseAddr[dataWidth-1:0];
      end
      progAddrHigh:
      begin
        regAddr = ch0AddrRegAddr;
        DB = baseAddr[addrWidth-1:dataWidth];
      end
      progCountLow:
      begin
        regAddr = ch0CountRegAddr;
        DB = baseCount[dataWidth-1:0];
      end
      progCountHigh:
      begin
        regAddr = ch0CountRegAddr;
        DB = baseCount[addrWidth-1:dataWidth];
      end
      default: writeCycle = 1'b0;       // bus idle
    endcase
  end

  assign CS_N = ~writeCycle;
  assign IOW_N = ~writeCycle;
  assign configured = (state == progDone);

  // hold acknowledge after a fixed latency, dropped the edge after HRQ goes away
  always_ff @(posedge CLK)
  begin
    if (RESET || !HRQ)
    begin
      HLDA <= 1'b0;
      holdCnt <= '0;
    end
    else if (holdCnt == holdBits'(holdWait))
      HLDA <= 1'b1;
    else
      holdCnt <= holdCnt + 1'b1;
  end

endmodule

/* logic/dmaPkg.sv */
package dmaPkg;

  localparam int dataWidth = 8;
  localparam int addrWidth = 16;
  localparam int regAddrWidth = 4;
  localparam int memAddrWidth = 8;              // memory decodes the low byte only
  localparam int memDepth = 1 << memAddrWidth;

  // channel 0 register map
  localparam logic [regAddrWidth-1:0] cmdRegAddr = 4'h8;
  localparam logic [regAddrWidth-1:0] modeRegAddr = 4'hB;
  localparam logic [regAddrWidth-1:0] ch0AddrRegAddr = 4'h0;
  localparam logic [regAddrWidth-1:0] ch0CountRegAddr = 4'h1;

  localparam int holdWait = 3;                  // cycles from HRQ seen to HLDA
  localparam int modeDecBit = 5;                // address decrement select
  localparam int cmdDisableBit = 2;             // controller disable

  typedef enum logic [2:0]
  {
    progIdle,
    progCmd,
    progMode,
    progAddrLow,
    progAddrHigh,
    progCountLow,
    progCountHigh,
    progDone
  } progState;

  typedef enum logic [2:0]
  {
    dmaIdle,
    dmaRequest,
    dmaAddress,
    dmaData,
    dmaEnd
  } dmaState;

  // mode bits 3..2
  typedef enum logic [1:0]
  {
    xferVerify = 2'b00,
    xferWrite = 2'b01,                          // I/O to memory
    xferRead = 2'b10                            // memory to I/O
  } xferType;

  // mode bits 7..6
  typedef enum logic [1:0]
  {
    modeDemand = 2'b00,
    modeSingle = 2'b01,
    modeBlock = 2'b10
  } xferMode;

endpackage
